//--- sim.f
verilog/rv_pkg.sv
verilog/rv_decoder.sv
verilog/rv_alu.sv
verilog/rv_regfile.sv
verilog/rv_pc_unit.sv
verilog/rv_core.sv
testbench/tb_rv_core.sv

//--- Makefile
TOP = tb_rv_core

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -qF '*** TEST PASSED ***' sim.log

lint:
	verilator --lint-only --timing -Wall -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

//--- testbench/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

  localparam logic [31:0] marker = 32'hdead_beef;
  localparam logic [31:0] st_base = 32'd256;
  localparam logic [6:0] opc_imm = 7'b0010011;

  logic clk;
  logic rst;
  logic [31:0] imem_data, dmem_rdata, imem_addr, dmem_addr, dmem_wdata;
  logic dmem_we, halt;

  logic [31:0] imem [256];
  logic [31:0] dmem [256];
  logic [31:0] exp_addr [64];
  logic [31:0] exp_data [64];
  logic [31:0] a, b;
  int n_instr = 0;
  int n_exp = 0;
  int st_cnt = 0;
  int cycles = 0;
  int errors = 0;
  int limit;

  rv_core #(.reset_pc(32'h0)) i_rv_core (
    .clk(clk), .rst(rst), .imem_data(imem_data), .dmem_rdata(dmem_rdata),
    .imem_addr(imem_addr), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
    .dmem_we(dmem_we), .halt(halt)
  );

  // both memories answer in the same cycle
  assign imem_data = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  always @(posedge clk) begin
    if (!rst && dmem_we) begin
      dmem[dmem_addr[9:2]] <= dmem_wdata;
      st_cnt <= st_cnt + 1;
    end
    if (!rst) begin
      cycles <= cycles + 1;
    end
  end

  function automatic logic [31:0] r_type(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3,
                                         int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(logic [31:0] imm, int rs1, logic [2:0] f3, int rd,
                                         logic [6:0] op);
    return {imm[11:0], 5'(rs1), f3, 5'(rd), op};
  endfunction

  function automatic logic [31:0] s_type(logic [31:0] imm, int rs2, int rs1);
    return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(logic [31:0] imm, int rs2, int rs1, logic [2:0] f3);
    return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] u_type(logic [31:0] upper, int rd, logic [6:0] op);
    return {upper[19:0], 5'(rd), op};
  endfunction

  function automatic logic [31:0] j_type(logic [31:0] imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), 7'b1101111};
  endfunction

  // expected ALU results straight from the ISA definitions
  function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic [31:0] x,
                                          logic [31:0] y);
    case (f3)
      3'd0: return alt ? x - y : x + y;
      3'd1: return x << y[4:0];
      3'd2: return {31'b0, $signed(x) < $signed(y)};
      3'd3: return {31'b0, x < y};
      3'd4: return x ^ y;
      3'd5: return alt ? 32'($signed(x) >>> y[4:0]) : x >> y[4:0];
      3'd6: return x | y;
      default: return x & y;
    endcase
  endfunction

  function automatic logic branch_ref(logic [2:0] f3, logic [31:0] x, logic [31:0] y);
    case (f3)
      3'd0: return x == y;
      3'd1: return x != y;
      3'd4: return $signed(x) < $signed(y);
      3'd5: return $signed(x) >= $signed(y);
      3'd6: return x < y;
      default: return x >= y;
    endcase
  endfunction

  task automatic emit(logic [31:0] instr);
    imem[n_instr] = instr;
    n_instr++;
  endtask

  task automatic load_const(int rd, logic [31:0] v);
    emit(u_type((v + 32'h800) >> 12, rd, 7'b0110111));
    emit(i_type(v, rd, 3'd0, rd, opc_imm));
  endtask

  // sw of rs2 to the next scoreboard slot
  task automatic expect_store(int rs2, logic [31:0] value);
    exp_addr[n_exp] = st_base + 32'(4 * n_exp);
    exp_data[n_exp] = value;
    emit(s_type(exp_addr[n_exp], rs2, 0));
    n_exp++;
  endtask

  task automatic build_program();
    logic [31:0] imm;
    logic [31:0] shamt;
    logic [31:0] upper;
    logic [31:0] pc0;
    int rs1;
    int rs2;
    imm = {{20{a[15]}}, a[15:4]};
    shamt = {27'b0, b[4:0]};
    upper = {12'b0, b[31:12]};
    // a sw at the reset pc, seen by the core while rst is still high
    expect_store(0, 32'h0);
    load_const(1, a);
    load_const(2, b);
    load_const(9, marker);
    for (int f = 0; f < 8; f++) begin
      emit(r_type(7'h00, 2, 1, 3'(f), 5));
      expect_store(5, alu_ref(3'(f), 1'b0, a, b));
    end
    emit(r_type(7'h20, 2, 1, 3'd0, 5));
    expect_store(5, alu_ref(3'd0, 1'b1, a, b));
    emit(r_type(7'h20, 2, 1, 3'd5, 5));
    expect_store(5, alu_ref(3'd5, 1'b1, a, b));
    // immediate group, shifts take their amount from b
    for (int f = 0; f < 8; f++) begin
      emit(i_type((f == 1 || f == 5) ? shamt : imm, 1, 3'(f), 5, opc_imm));
      expect_store(5, alu_ref(3'(f), 1'b0, a, (f == 1 || f == 5) ? shamt : imm));
    end
    emit(i_type({20'b0, 7'h20, shamt[4:0]}, 1, 3'd5, 5, opc_imm));
    expect_store(5, alu_ref(3'd5, 1'b1, a, shamt));
    emit(u_type(upper, 6, 7'b0110111));
    expect_store(6, {upper[19:0], 12'b0});
    pc0 = 32'(4 * n_instr);
    emit(u_type(upper, 6, 7'b0010111));
    expect_store(6, pc0 + {upper[19:0], 12'b0});
    // x0 ignores the write
    emit(i_type(imm, 1, 3'd0, 0, opc_imm));
    expect_store(0, 32'h0);
    expect_store(1, a);
    emit(i_type(exp_addr[n_exp-1], 0, 3'b010, 8, 7'b0000011));
    expect_store(8, a);
    // operand pairs (x1,x2), (x2,x1) and (x1,x1) give each branch both outcomes
    for (int f = 0; f < 8; f++) begin
      if (f != 2 && f != 3) begin
        for (int k = 0; k < 3; k++) begin
          rs1 = (k == 1) ? 2 : 1;
          rs2 = (k == 0) ? 2 : 1;
          emit(b_type(32'd8, rs2, rs1, 3'(f)));
          if (branch_ref(3'(f), (rs1 == 1) ? a : b, (rs2 == 1) ? a : b)) begin
            emit(s_type(st_base - 32'd4, 9, 0));
          end else begin
            expect_store(1, a);
          end
        end
      end
    end
    pc0 = 32'(4 * n_instr);
    emit(j_type(32'd8, 11));
    emit(s_type(st_base - 32'd4, 9, 0));
    expect_store(11, pc0 + 32'd4);
    // jalr target has bit 0 set, the core must clear it
    pc0 = 32'(4 * n_instr);
    load_const(13, pc0 + 32'd16);
    emit(i_type(32'd1, 13, 3'd0, 12, 7'b1100111));
    emit(s_type(st_base - 32'd4, 9, 0));
    expect_store(12, pc0 + 32'd12);
    emit(32'h0000_0073);
  endtask

  a_reset_pc: assert property (@(posedge clk) $fell(rst) |-> imem_addr == 32'h0)
    else begin
      errors++;
      $display("Fail %0t: pc after reset is %h", $time, $sampled(imem_addr));
    end

  a_we_in_reset: assert property (@(posedge clk) rst |-> !dmem_we)
    else begin
      errors++;
      $display("Fail %0t: dmem_we high during reset", $time);
    end

  a_we_only_sw: assert property (@(posedge clk) disable iff (rst)
    dmem_we |-> imem_data[6:0] == 7'b0100011)
    else begin
      errors++;
      $display("Fail %0t: dmem_we high for %h", $time, $sampled(imem_data));
    end

  a_store: assert property (@(posedge clk) disable iff (rst)
    dmem_we |-> dmem_addr == exp_addr[st_cnt] && dmem_wdata == exp_data[st_cnt])
    else begin
      errors++;
      $display("Fail %0t: store %0d wrote %h to %h", $time, $sampled(st_cnt),
               $sampled(dmem_wdata), $sampled(dmem_addr));
    end

  a_no_marker: assert property (@(posedge clk) disable iff (rst)
    dmem_we |-> dmem_wdata != marker)
    else begin
      errors++;
      $display("Fail %0t: skipped store executed at pc %h", $time, $sampled(imem_addr));
    end

  a_halt_hold: assert property (@(posedge clk) disable iff (rst)
    halt |=> halt && $stable(imem_addr))
    else begin
      errors++;
      $display("Fail %0t: pc moved to %h while halted", $time, $sampled(imem_addr));
    end

  a_halt_no_store: assert property (@(posedge clk) disable iff (rst) halt |-> !dmem_we)
    else begin
      errors++;
      $display("Fail %0t: store while halted", $time);
    end

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    void'($urandom(22669));
    a = $urandom;
    b = $urandom;
    if (a == b) begin
      b = ~a;
    end
    for (int i = 0; i < 256; i++) begin
      imem[i] = 32'h0;
      dmem[i] = 32'h0;
    end
    build_program();
    limit = 4 * n_instr;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    while (!halt && cycles < limit) begin
      @(posedge clk);
    end
    if (!halt) begin
      errors++;
      $display("timeout: ecall not reached within %0d cycles", limit);
    end else begin
      // let the halt checks run for a few cycles
      repeat (4) @(posedge clk);
    end
    if (st_cnt != n_exp) begin
      errors++;
      $display("Fail %0t: %0d stores seen, %0d expected", $time, st_cnt, n_exp);
    end
    $display("stores: %0d of %0d, errors: %0d", st_cnt, n_exp, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- verilog/rv_core.sv
`timescale 1ns/1ps

module rv_core #(
  parameter rv_pkg::word_t reset_pc = '0
) (
  input  logic          clk,
  input  logic          rst,
  input  rv_pkg::word_t imem_data,
  input  rv_pkg::word_t dmem_rdata,
  output rv_pkg::word_t imem_addr,
  output rv_pkg::word_t dmem_addr,
  output rv_pkg::word_t dmem_wdata,
  output logic          dmem_we,
  output logic          halt
);

  rv_pkg::reg_idx_t rs1_idx, rs2_idx, rd_idx;
  rv_pkg::word_t imm, pc, pc_plus4;
  rv_pkg::word_t rs1_data, rs2_data, rd_data;
  rv_pkg::word_t alu_a, alu_b, alu_result;
  rv_pkg::alu_op_t alu_op;
  rv_pkg::wb_sel_t wb_sel;
  logic [2:0] branch_funct3;
  logic alu_a_pc, alu_b_imm, reg_we, mem_we;
  logic is_branch, is_jal, is_jalr, branch_taken;

  rv_decoder i_rv_decoder (
    .instr(imem_data), .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rd_idx(rd_idx),
    .imm(imm), .alu_op(alu_op), .alu_a_pc(alu_a_pc), .alu_b_imm(alu_b_imm),
    .reg_we(reg_we), .mem_we(mem_we), .is_branch(is_branch), .is_jal(is_jal),
    .is_jalr(is_jalr), .halt(halt), .branch_funct3(branch_funct3), .wb_sel(wb_sel)
  );

  // ecall blocks the write-back along with the pc update
  rv_regfile i_rv_regfile (
    .clk(clk), .rst(rst), .we(reg_we && !halt), .rd_idx(rd_idx),
    .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rd_data(rd_data),
    .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  assign alu_a = alu_a_pc ? pc : rs1_data;
  assign alu_b = alu_b_imm ? imm : rs2_data;

  rv_alu i_rv_alu (
    .a(alu_a), .b(alu_b), .op(alu_op), .funct3(branch_funct3),
    .result(alu_result), .branch_taken(branch_taken)
  );

  rv_pc_unit #(.reset_pc(reset_pc)) i_rv_pc_unit (
    .clk(clk), .rst(rst), .halt(halt), .is_branch(is_branch), .is_jal(is_jal),
    .is_jalr(is_jalr), .branch_taken(branch_taken), .imm(imm),
    .alu_result(alu_result), .pc(pc), .pc_plus4(pc_plus4)
  );

  always_comb begin
    case (wb_sel)
      rv_pkg::wb_load: rd_data = dmem_rdata;
      rv_pkg::wb_link: rd_data = pc_plus4;
      default: rd_data = alu_result;
    endcase
  end

  assign imem_addr = pc;
  // alu sum is rs1 + offset for lw and sw
  assign dmem_addr = alu_result;
  assign dmem_wdata = rs2_data;
  // a store sitting at the reset pc stays masked while rst is high
  assign dmem_we = mem_we && !rst;

  a_mem_aligned: assert property (
    @(posedge clk) disable iff (rst)
    (mem_we || wb_sel == rv_pkg::wb_load) |-> dmem_addr[1:0] == 2'b00
  ) else $error("misaligned data access at %h", dmem_addr);

endmodule

//--- verilog/rv_pc_unit.sv
`timescale 1ns/1ps

module rv_pc_unit #(
  parameter rv_pkg::word_t reset_pc = '0
) (
  input  logic          clk,
  input  logic          rst,
  input  logic          halt,
  input  logic          is_branch,
  input  logic          is_jal,
  input  logic          is_jalr,
  input  logic          branch_taken,
  input  rv_pkg::word_t imm,
  input  rv_pkg::word_t alu_result,
  output rv_pkg::word_t pc,
  output rv_pkg::word_t pc_plus4
);

  rv_pkg::word_t pc_next;

  // also the link value for jal and jalr
  assign pc_plus4 = pc + 32'd4;

  always_comb begin
    if (halt) begin
      pc_next = pc;
    end else if (is_jalr) begin
      pc_next = {alu_result[rv_pkg::xlen-1:1], 1'b0};
    end else if (is_jal || (is_branch && branch_taken)) begin
      pc_next = pc + imm;
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= reset_pc;
    end else begin
      pc <= pc_next;
    end
  end

  a_pc_aligned: assert property (
    @(posedge clk) disable iff (rst)
    pc[1:0] == 2'b00
  ) else $error("pc not word-aligned: %h", pc);

endmodule

//--- verilog/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
  input  logic             clk,
  input  logic             rst,
  input  logic             we,
  input  rv_pkg::reg_idx_t rd_idx,
  input  rv_pkg::reg_idx_t rs1_idx,
  input  rv_pkg::reg_idx_t rs2_idx,
  input  rv_pkg::word_t    rd_data,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data
);

  localparam int num_regs = 32;

  rv_pkg::word_t regs [num_regs];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[rd_idx] <= rd_data;
    end
  end

  // x0 is hard-wired, reads see the value before this cycle's write
  assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
  assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

  a_x0_zero: assert property (
    @(posedge clk) disable iff (rst)
    we |=> regs[0] == '0
  ) else $error("register x0 changed after a write");

endmodule

//--- verilog/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  input  rv_pkg::alu_op_t op,
  input  logic [2:0]      funct3,
  output rv_pkg::word_t   result,
  output logic            branch_taken
);

  logic [4:0] shamt;
  logic lt_signed;
  logic lt_unsigned;

  assign shamt = b[4:0];
  assign lt_signed = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      rv_pkg::alu_add: result = a + b;
      rv_pkg::alu_sub: result = a - b;
      rv_pkg::alu_sll: result = a << shamt;
      rv_pkg::alu_slt: result = {{(rv_pkg::xlen-1){1'b0}}, lt_signed};
      rv_pkg::alu_sltu: result = {{(rv_pkg::xlen-1){1'b0}}, lt_unsigned};
      rv_pkg::alu_xor: result = a ^ b;
      rv_pkg::alu_srl: result = a >> shamt;
      rv_pkg::alu_sra: result = $signed(a) >>> shamt;
      rv_pkg::alu_or: result = a | b;
      rv_pkg::alu_and: result = a & b;
      rv_pkg::alu_pass_b: result = b;
      default: result = a + b;
    endcase
  end

  // compare rs1 against rs2 independently of the arithmetic result
  always_comb begin
    case (funct3)
      rv_pkg::br_eq: branch_taken = (a == b);
      rv_pkg::br_ne: branch_taken = (a != b);
      rv_pkg::br_lt: branch_taken = lt_signed;
      rv_pkg::br_ge: branch_taken = !lt_signed;
      rv_pkg::br_ltu: branch_taken = lt_unsigned;
      rv_pkg::br_geu: branch_taken = !lt_unsigned;
      default: branch_taken = 1'b0;
    endcase
  end

endmodule

//--- verilog/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
  input  rv_pkg::word_t    instr,
  output rv_pkg::reg_idx_t rs1_idx,
  output rv_pkg::reg_idx_t rs2_idx,
  output rv_pkg::reg_idx_t rd_idx,
  output rv_pkg::word_t    imm,
  output rv_pkg::alu_op_t  alu_op,
  output logic             alu_a_pc,
  output logic             alu_b_imm,
  output logic             reg_we,
  output logic             mem_we,
  output logic             is_branch,
  output logic             is_jal,
  output logic             is_jalr,
  output logic             halt,
  output logic [2:0]       branch_funct3,
  output rv_pkg::wb_sel_t  wb_sel
);

  // only full-word memory accesses are supported
  localparam logic [2:0] f3_word = 3'b010;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic writes_rd;
  rv_pkg::alu_op_t arith_op;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rd_idx = instr[11:7];
  assign rs1_idx = instr[19:15];
  assign rs2_idx = instr[24:20];
  assign branch_funct3 = funct3;

  // immediate format follows the opcode, I-type otherwise
  always_comb begin
    case (opcode)
      rv_pkg::op_lui, rv_pkg::op_auipc: imm = {instr[31:12], 12'b0};
      rv_pkg::op_jal: imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      rv_pkg::op_branch: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      rv_pkg::op_store: imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
      default: imm = {{21{instr[31]}}, instr[30:20]};
    endcase
  end

  // shared by register-register and register-immediate groups
  always_comb begin
    case (funct3)
      3'b000: begin
        arith_op = (opcode == rv_pkg::op_reg && funct7 == rv_pkg::f7_alt) ?
                   rv_pkg::alu_sub : rv_pkg::alu_add;
      end
      3'b001: arith_op = rv_pkg::alu_sll;
      3'b010: arith_op = rv_pkg::alu_slt;
      3'b011: arith_op = rv_pkg::alu_sltu;
      3'b100: arith_op = rv_pkg::alu_xor;
      3'b101: arith_op = (funct7 == rv_pkg::f7_alt) ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      3'b110: arith_op = rv_pkg::alu_or;
      default: arith_op = rv_pkg::alu_and;
    endcase
  end

  always_comb begin
    alu_op = rv_pkg::alu_add;
    alu_a_pc = 1'b0;
    alu_b_imm = 1'b0;
    writes_rd = 1'b0;
    mem_we = 1'b0;
    is_branch = 1'b0;
    is_jal = 1'b0;
    is_jalr = 1'b0;
    halt = 1'b0;
    wb_sel = rv_pkg::wb_alu;
    case (opcode)
      rv_pkg::op_lui: begin
        alu_op = rv_pkg::alu_pass_b;
        alu_b_imm = 1'b1;
        writes_rd = 1'b1;
      end
      rv_pkg::op_auipc: begin
        alu_a_pc = 1'b1;
        alu_b_imm = 1'b1;
        writes_rd = 1'b1;
      end
      rv_pkg::op_jal: begin
        is_jal = 1'b1;
        writes_rd = 1'b1;
        wb_sel = rv_pkg::wb_link;
      end
      rv_pkg::op_jalr: begin
        // alu forms rs1 + imm, the pc unit clears bit 0
        is_jalr = 1'b1;
        alu_b_imm = 1'b1;
        writes_rd = 1'b1;
        wb_sel = rv_pkg::wb_link;
      end
      rv_pkg::op_branch: is_branch = 1'b1;
      rv_pkg::op_load: begin
        if (funct3 == f3_word) begin
          alu_b_imm = 1'b1;
          writes_rd = 1'b1;
          wb_sel = rv_pkg::wb_load;
        end
      end
      rv_pkg::op_store: begin
        if (funct3 == f3_word) begin
          alu_b_imm = 1'b1;
          mem_we = 1'b1;
        end
      end
      rv_pkg::op_imm: begin
        alu_op = arith_op;
        alu_b_imm = 1'b1;
        writes_rd = 1'b1;
      end
      rv_pkg::op_reg: begin
        // other funct7 values (M extension) fall through as no-ops
        if (funct7 == 7'b0 || funct7 == rv_pkg::f7_alt) begin
          alu_op = arith_op;
          writes_rd = 1'b1;
        end
      end
      rv_pkg::op_system: halt = (instr[31:7] == 25'b0);
      default: ;
    endcase
  end

  assign reg_we = writes_rd && (rd_idx != '0);

endmodule

//--- verilog/rv_pkg.sv
package rv_pkg;

  // datapath widths
  localparam int xlen = 32;
  localparam int reg_addr_w = 5;

  typedef logic [xlen-1:0] word_t;
  typedef logic [reg_addr_w-1:0] reg_idx_t;

  // base opcodes, instr[6:0]
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_system = 7'b1110011;

  // funct7 for sub and sra/srai
  localparam logic [6:0] f7_alt = 7'b0100000;

  // branch conditions, funct3
  localparam logic [2:0] br_eq  = 3'b000;
  localparam logic [2:0] br_ne  = 3'b001;
  localparam logic [2:0] br_lt  = 3'b100;
  localparam logic [2:0] br_ge  = 3'b101;
  localparam logic [2:0] br_ltu = 3'b110;
  localparam logic [2:0] br_geu = 3'b111;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_t;

  // register write-back source
  typedef enum logic [1:0] {
    wb_alu,
    wb_load,
    wb_link
  } wb_sel_t;

endpackage
